// File: source/bus_slave_pkg.sv
// bus slave package
// sizes shared by the host bus slave: bus byte, stored word,
// word address and protocol error counter
// all blocks refer to these by scoped names

`default_nettype none

package bus_slave_pkg;

	// one host bus transfer
	localparam int bus_width = 8;

	// bus phases that make up one stored word
	localparam int beats_per_word = 4;

	// stored word, msb byte travels first
	localparam int word_width = bus_width * beats_per_word;

	localparam int beat_index_width = 2; // byte counter, runs 3 down to 0

	// word address is loaded from a single bus byte
	localparam int address_width = bus_width;

	localparam int memory_depth = 256; // words behind the slave

	// protocol errors, saturating
	localparam int error_count_width = 16;

endpackage

`default_nettype wire

// File: source/input_synchronizer.sv
// input synchronizer
// brings the host control levels and the bus byte into the clock domain
// through two flops each, and turns the synchronized enable into
// one-cycle start and end pulses for the sequencer

`timescale 1ns/1ps
`default_nettype none

module input_synchronizer (
	input  wire logic                                clock,
	input  wire logic                                reset,
	input  wire logic                                enable,
	input  wire logic                                read,
	input  wire logic                                register_select,
	input  wire logic [bus_slave_pkg::bus_width-1:0] bus_in,
	output logic                                     sync_read,
	output logic                                     sync_register_select,
	output logic      [bus_slave_pkg::bus_width-1:0] sync_bus,
	output logic                                     phase_start,
	output logic                                     phase_end
);

	logic                                enable_meta;
	logic                                enable_sync;
	logic                                enable_last; // one more stage for edges
	logic                                read_meta;
	logic                                register_select_meta;
	logic [bus_slave_pkg::bus_width-1:0] bus_meta;

	always_ff @(posedge clock) begin
		if (reset) begin
			enable_meta          <= 1'b0;
			enable_sync          <= 1'b0;
			enable_last          <= 1'b0;
			read_meta            <= 1'b0;
			sync_read            <= 1'b0;
			register_select_meta <= 1'b0;
			sync_register_select <= 1'b0;
			bus_meta             <= '0;
			sync_bus             <= '0;
			phase_start          <= 1'b0;
			phase_end            <= 1'b0;
		end else begin
			enable_meta          <= enable;
			enable_sync          <= enable_meta;
			enable_last          <= enable_sync;
			read_meta            <= read;
			sync_read            <= read_meta;
			register_select_meta <= register_select;
			sync_register_select <= register_select_meta;
			bus_meta             <= bus_in; // host holds it stable around enable
			sync_bus             <= bus_meta;
			// registered edge pulses, two clocks after enable is sampled
			phase_start          <= enable_sync & ~enable_last;
			phase_end            <= ~enable_sync & enable_last;
		end
	end

endmodule

`default_nettype wire

// File: source/transaction_sequencer.sv
// transaction sequencer
// decodes each host bus phase as address, write or read
// write bytes are assembled msb first into a word and committed after
// the fourth byte; read bytes are taken from the addressed word msb first
// an address phase that arrives mid-word counts as a protocol error

`timescale 1ns/1ps
`default_nettype none

module transaction_sequencer (
	input  wire logic                                        clock,
	input  wire logic                                        reset,
	input  wire logic                                        sync_read,
	input  wire logic                                        sync_register_select,
	input  wire logic [bus_slave_pkg::bus_width-1:0]         sync_bus,
	input  wire logic                                        phase_start,
	input  wire logic                                        phase_end,
	input  wire logic [bus_slave_pkg::word_width-1:0]        read_word,
	output logic      [bus_slave_pkg::address_width-1:0]     word_address,
	output logic      [bus_slave_pkg::word_width-1:0]        write_word,
	output logic                                             write_strobe,
	output logic      [bus_slave_pkg::bus_width-1:0]         bus_out,
	output logic                                             bus_drive,
	output logic                                             ack_valid,
	output logic      [bus_slave_pkg::error_count_width-1:0] error_count
);

	// byte counters run from the msb slot down to slot 0
	logic [bus_slave_pkg::beat_index_width-1:0] write_beat;
	logic [bus_slave_pkg::beat_index_width-1:0] read_beat;
	logic                                       write_active; // phase in progress is a write
	logic                                       read_active;
	logic                                       address_phase;
	logic                                       write_phase;
	logic                                       read_phase;
	logic                                       mid_word;

	// all ones is the msb slot
	function automatic logic [bus_slave_pkg::beat_index_width-1:0] next_beat(
		input logic [bus_slave_pkg::beat_index_width-1:0] beat
	);
		if (beat == '0) begin
			return {bus_slave_pkg::beat_index_width{1'b1}}; // wrap to msb
		end
		return beat - 1'b1;
	endfunction

	// read wins over register_select
	assign read_phase    = sync_read;
	assign address_phase = ~sync_read & ~sync_register_select;
	assign write_phase   = ~sync_read & sync_register_select;

	assign mid_word = (write_beat != {bus_slave_pkg::beat_index_width{1'b1}})
		|| (read_beat != {bus_slave_pkg::beat_index_width{1'b1}});

	assign bus_drive = sync_read; // slave owns the bus while the host reads

	always_ff @(posedge clock) begin
		if (reset) begin
			word_address <= '0;
			write_strobe <= 1'b0;
			bus_out      <= '0;
			ack_valid    <= 1'b0;
			error_count  <= '0;
			write_beat   <= {bus_slave_pkg::beat_index_width{1'b1}};
			read_beat    <= {bus_slave_pkg::beat_index_width{1'b1}};
			write_active <= 1'b0;
			read_active  <= 1'b0;
		end else begin
			write_strobe <= 1'b0; // single-cycle pulse

			if (phase_start) begin
				ack_valid    <= 1'b1;
				write_active <= write_phase;
				read_active  <= read_phase;
				if (address_phase) begin
					word_address <= sync_bus;
					if (mid_word) begin
						// partial word abandoned
						if (error_count != {bus_slave_pkg::error_count_width{1'b1}}) begin
							error_count <= error_count + 1'b1;
						end
					end
					write_beat <= {bus_slave_pkg::beat_index_width{1'b1}};
					read_beat  <= {bus_slave_pkg::beat_index_width{1'b1}};
				end else if (write_phase) begin
					if (write_beat == '0) begin
						write_strobe <= 1'b1; // last byte, commit next edge
					end
				end else begin
					// same edge as ack_valid rise
					bus_out <= read_word[read_beat * bus_slave_pkg::bus_width +:
						bus_slave_pkg::bus_width];
				end
			end

			if (phase_end) begin
				ack_valid    <= 1'b0;
				write_active <= 1'b0;
				read_active  <= 1'b0;
				if (write_active) begin
					write_beat <= next_beat(write_beat);
				end
				if (read_active) begin
					read_beat <= next_beat(read_beat);
				end
			end
		end
	end

	// word assembly register, payload only
	always_ff @(posedge clock) begin
		if (phase_start && write_phase) begin
			write_word[write_beat * bus_slave_pkg::bus_width +: bus_slave_pkg::bus_width]
				<= sync_bus;
		end
	end

endmodule

`default_nettype wire

// File: source/word_memory.sv
// word memory
// single-port synchronous RAM of 32-bit words behind the bus slave
// writes on the write strobe and registers the addressed word every
// clock, so a read in the write cycle returns the old contents

`timescale 1ns/1ps
`default_nettype none

module word_memory (
	input  wire logic                                    clock,
	input  wire logic                                    write_strobe,
	input  wire logic [bus_slave_pkg::address_width-1:0] word_address,
	input  wire logic [bus_slave_pkg::word_width-1:0]    write_word,
	output logic      [bus_slave_pkg::word_width-1:0]    read_word
);

	// contents are undefined until written
	logic [bus_slave_pkg::word_width-1:0] storage [bus_slave_pkg::memory_depth];

	always_ff @(posedge clock) begin
		if (write_strobe) begin
			storage[word_address] <= write_word;
		end
	end

	// registered read port
	always_ff @(posedge clock) begin
		read_word <= storage[word_address]; // read before write
	end

endmodule

`default_nettype wire

// File: source/bus_slave_top.sv
// host bus slave top level
// byte-wide slave for an external controller: synchronizer, then
// transaction sequencer, then word memory
// the host bus is split into bus_in, bus_out and bus_drive

`timescale 1ns/1ps
`default_nettype none

module bus_slave_top (
	input  wire logic                                        clock,
	input  wire logic                                        reset,
	input  wire logic                                        enable,
	input  wire logic                                        read,
	input  wire logic                                        register_select,
	input  wire logic [bus_slave_pkg::bus_width-1:0]         bus_in,
	output logic      [bus_slave_pkg::bus_width-1:0]         bus_out,
	output logic                                             bus_drive,
	output logic                                             ack_valid,
	output logic      [bus_slave_pkg::error_count_width-1:0] error_count
);

	logic                                    sync_read;
	logic                                    sync_register_select;
	logic [bus_slave_pkg::bus_width-1:0]     sync_bus;
	logic                                    phase_start;
	logic                                    phase_end;
	logic [bus_slave_pkg::address_width-1:0] word_address;
	logic [bus_slave_pkg::word_width-1:0]    write_word;
	logic                                    write_strobe;
	logic [bus_slave_pkg::word_width-1:0]    read_word;

	input_synchronizer synchronizer (
		.clock                (clock),
		.reset                (reset),
		.enable               (enable),
		.read                 (read),
		.register_select      (register_select),
		.bus_in               (bus_in),
		.sync_read            (sync_read),
		.sync_register_select (sync_register_select),
		.sync_bus             (sync_bus),
		.phase_start          (phase_start),
		.phase_end            (phase_end)
	);

	transaction_sequencer sequencer (
		.clock                (clock),
		.reset                (reset),
		.sync_read            (sync_read),
		.sync_register_select (sync_register_select),
		.sync_bus             (sync_bus),
		.phase_start          (phase_start),
		.phase_end            (phase_end),
		.read_word            (read_word),
		.word_address         (word_address),
		.write_word           (write_word),
		.write_strobe         (write_strobe),
		.bus_out              (bus_out),
		.bus_drive            (bus_drive),
		.ack_valid            (ack_valid),
		.error_count          (error_count)
	);

	word_memory memory (
		.clock        (clock),
		.write_strobe (write_strobe),
		.word_address (word_address),
		.write_word   (write_word),
		.read_word    (read_word)
	);

endmodule

`default_nettype wire

// File: testbench/bus_slave_assertions.sv
// protocol assertions for the host bus slave
// bound to the top level, they watch ack_valid, bus_drive and error_count

`timescale 1ns/1ps
`default_nettype none

module bus_slave_assertions (
	input wire logic                                        clock,
	input wire logic                                        reset,
	input wire logic                                        read,
	input wire logic                                        bus_drive,
	input wire logic                                        ack_valid,
	input wire logic [bus_slave_pkg::error_count_width-1:0] error_count
);

	int failure_count = 0; // read by the testbench at the end

	// reset clears ack on its first edge, no phase can start the clock after
	ack_low_after_reset: assert property (@(posedge clock)
		($past(reset) || $past(reset, 2)) |-> !ack_valid)
		else begin
			failure_count = failure_count + 1;
			$error("ack_valid high during reset or the clock after it");
		end

	drive_follows_read: assert property (@(posedge clock)
		(!reset && !$past(reset) && !$past(reset, 2)) |-> bus_drive == $past(read, 2))
		else begin
			failure_count = failure_count + 1;
			$error("bus_drive does not follow read within 2 clocks");
		end

	errors_never_drop: assert property (@(posedge clock)
		(!reset && !$past(reset)) |-> error_count >= $past(error_count))
		else begin
			failure_count = failure_count + 1;
			$error("error_count decreased outside reset");
		end

endmodule

bind bus_slave_top bus_slave_assertions protocol_assertions (
	.clock       (clock),
	.reset       (reset),
	.read        (read),
	.bus_drive   (bus_drive),
	.ack_valid   (ack_valid),
	.error_count (error_count)
);

`default_nettype wire

// File: testbench/bus_slave_checker.sv
// bus slave checker
// collects read bytes at each ack_valid rise, rebuilds the word msb first,
// and scores every test against the expected word and error count

`timescale 1ns/1ps
`default_nettype none

module bus_slave_checker (
	input  wire logic                                        clock,
	input  wire logic                                        reset,
	input  wire logic                                        bus_drive,
	input  wire logic                                        ack_valid,
	input  wire logic [bus_slave_pkg::bus_width-1:0]         bus_out,
	input  wire logic [bus_slave_pkg::error_count_width-1:0] error_count,
	input  wire logic [127:0]                                test_name,
	input  wire logic                                        check_word,
	input  wire logic [bus_slave_pkg::word_width-1:0]        expected_word,
	input  wire logic [bus_slave_pkg::error_count_width-1:0] expected_errors,
	input  wire logic                                        test_done,
	output int                                               pass_count,
	output int                                               fail_count
);

	logic                                 ack_last;
	logic [bus_slave_pkg::word_width-1:0] read_back; // bytes shifted in msb first
	int                                   byte_count;

	initial begin
		pass_count = 0;
		fail_count = 0;
	end

	task automatic score_test();
		logic ok;
		ok = 1'b1;
		if (check_word && byte_count != bus_slave_pkg::beats_per_word) begin
			$display("test %0s: got %0d read bytes instead of a full word", test_name, byte_count);
			ok = 1'b0;
		end else if (check_word && read_back != expected_word) begin
			$display("MISMATCH %0s word expected %h actual %h", test_name, expected_word,
				read_back);
			ok = 1'b0;
		end
		if (error_count != expected_errors) begin
			$display("MISMATCH %0s error_count expected %0d actual %0d", test_name,
				expected_errors, error_count);
			ok = 1'b0;
		end
		if (ack_valid) begin
			$display("test %0s: ack_valid still high after the last phase", test_name);
			ok = 1'b0;
		end
		if (ok) begin
			pass_count = pass_count + 1;
			$display("pass %0s", test_name);
		end else begin
			fail_count = fail_count + 1;
		end
	endtask

	always @(posedge clock) begin
		ack_last <= ack_valid;
		if (reset) begin
			byte_count <= 0;
		end else if (test_done) begin
			score_test();
			byte_count <= 0;
		end else if (ack_valid && !ack_last && bus_drive) begin
			read_back  <= {read_back[bus_slave_pkg::word_width-bus_slave_pkg::bus_width-1:0],
				bus_out};
			byte_count <= byte_count + 1;
		end
	end

endmodule

`default_nettype wire

// File: testbench/bus_slave_tb.sv
// host bus slave testbench
// walks a table of write, read, partial and reset tests through the DUT
// as a host would, and hands the expected values to the checker

`timescale 1ns/1ps
`default_nettype none

module bus_slave_tb;

	typedef enum logic [2:0] {
		op_write, op_read, op_partial_write, op_partial_read, op_reset
	} operation_kind;

	typedef struct {
		logic [127:0]  name;
		operation_kind operation;
		logic [7:0]    address;
		logic [31:0]   data;
		int            bytes; // only for partial tests
		logic [31:0]   expected_word;
		logic [15:0]   expected_errors;
	} test_row;

	localparam int test_count   = 17;
	localparam int reset_cycles = 8;
	localparam int cycle_limit  = (test_count * 5 * 16 + reset_cycles) * 2;

	logic                                        clock;
	logic                                        reset;
	logic                                        enable;
	logic                                        read;
	logic                                        register_select;
	logic [bus_slave_pkg::bus_width-1:0]         bus_in;
	logic [bus_slave_pkg::bus_width-1:0]         bus_out;
	logic                                        bus_drive;
	logic                                        ack_valid;
	logic [bus_slave_pkg::error_count_width-1:0] error_count;
	logic [127:0]                                test_name;
	logic                                        check_word;
	logic [bus_slave_pkg::word_width-1:0]        expected_word;
	logic [bus_slave_pkg::error_count_width-1:0] expected_errors;
	logic                                        test_done;
	int                                          pass_count;
	int                                          fail_count;
	int                                          cycle_count = 0;
	int                                          assertion_failures;
	int                                          index;
	test_row                                     rows [test_count];

	bus_slave_top u_bus_slave_top (
		.clock (clock), .reset (reset), .enable (enable), .read (read),
		.register_select (register_select), .bus_in (bus_in), .bus_out (bus_out),
		.bus_drive (bus_drive), .ack_valid (ack_valid), .error_count (error_count)
	);

	bus_slave_checker read_checker (
		.clock (clock), .reset (reset), .bus_drive (bus_drive), .ack_valid (ack_valid),
		.bus_out (bus_out), .error_count (error_count), .test_name (test_name),
		.check_word (check_word), .expected_word (expected_word),
		.expected_errors (expected_errors), .test_done (test_done),
		.pass_count (pass_count), .fail_count (fail_count)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: tests did not finish within %0d clocks", cycle_limit);
			$display("Test FAILED");
			$finish;
		end
	end

	// one bus phase: levels first, then enable until ack rises and falls
	task automatic drive_phase(input logic is_read, input logic select, input logic [7:0] value);
		@(posedge clock);
		read            <= is_read;
		register_select <= select;
		bus_in          <= value;
		repeat (3) @(posedge clock);
		enable <= 1'b1;
		@(posedge clock);
		while (ack_valid !== 1'b1) @(posedge clock);
		enable <= 1'b0;
		@(posedge clock);
		while (ack_valid !== 1'b0) @(posedge clock);
	endtask

	task automatic apply_test(input test_row row);
		int   beat;
		int   beat_total;
		logic is_read;
		is_read    = (row.operation == op_read) || (row.operation == op_partial_read);
		beat_total = (row.operation == op_write || row.operation == op_read) ? 4 : row.bytes;
		@(posedge clock);
		test_name       <= row.name;
		check_word      <= (row.operation == op_read);
		expected_word   <= row.expected_word;
		expected_errors <= row.expected_errors;
		if (row.operation == op_reset) begin
			reset <= 1'b1;
			repeat (reset_cycles) @(posedge clock);
			reset <= 1'b0;
		end else begin
			drive_phase(1'b0, 1'b0, row.address);
			for (beat = 0; beat < beat_total; beat++) begin
				drive_phase(is_read, 1'b1, row.data[31 - 8 * beat -: 8]); // msb first
			end
			if (row.operation == op_partial_write || row.operation == op_partial_read) begin
				drive_phase(1'b0, 1'b0, row.address); // address phase mid-word
			end
		end
		@(posedge clock);
		test_done <= 1'b1;
		@(posedge clock);
		test_done <= 1'b0;
	endtask

	initial begin
		reset           = 1'b1;
		enable          = 1'b0;
		read            = 1'b0;
		register_select = 1'b0;
		bus_in          = '0;
		test_name       = '0;
		check_word      = 1'b0;
		expected_word   = '0;
		expected_errors = '0;
		test_done       = 1'b0;
		// name, operation, address, data, bytes, expected word, expected error_count
		rows[0]  = '{"write_a", op_write, 8'h10, 32'hdeadbeef, 4, 32'h0, 16'd0};
		rows[1]  = '{"read_a", op_read, 8'h10, 32'h0, 4, 32'hdeadbeef, 16'd0};
		rows[2]  = '{"write_b", op_write, 8'h3c, 32'h12345678, 4, 32'h0, 16'd0};
		rows[3]  = '{"write_c", op_write, 8'hff, 32'ha5c30f96, 4, 32'h0, 16'd0};
		rows[4]  = '{"read_c", op_read, 8'hff, 32'h0, 4, 32'ha5c30f96, 16'd0};
		rows[5]  = '{"read_b", op_read, 8'h3c, 32'h0, 4, 32'h12345678, 16'd0};
		rows[6]  = '{"read_a_again", op_read, 8'h10, 32'h0, 4, 32'hdeadbeef, 16'd0};
		rows[7]  = '{"rewrite_b", op_write, 8'h3c, 32'h0badf00d, 4, 32'h0, 16'd0};
		rows[8]  = '{"read_new_b", op_read, 8'h3c, 32'h0, 4, 32'h0badf00d, 16'd0};
		rows[9]  = '{"partial_write", op_partial_write, 8'h10, 32'h11223344, 2, 32'h0, 16'd1};
		rows[10] = '{"read_a_kept", op_read, 8'h10, 32'h0, 4, 32'hdeadbeef, 16'd1};
		rows[11] = '{"partial_read", op_partial_read, 8'hff, 32'h0, 3, 32'h0, 16'd2};
		rows[12] = '{"read_c_restart", op_read, 8'hff, 32'h0, 4, 32'ha5c30f96, 16'd2};
		rows[13] = '{"reset_again", op_reset, 8'h00, 32'h0, 0, 32'h0, 16'd0};
		rows[14] = '{"write_d", op_write, 8'h00, 32'hcafe0001, 4, 32'h0, 16'd0};
		rows[15] = '{"read_d", op_read, 8'h00, 32'h0, 4, 32'hcafe0001, 16'd0};
		rows[16] = '{"read_b_kept", op_read, 8'h3c, 32'h0, 4, 32'h0badf00d, 16'd0};
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;
		for (index = 0; index < test_count; index++) begin
			apply_test(rows[index]);
		end
		repeat (2) @(posedge clock); // let the checker finish scoring
		assertion_failures = u_bus_slave_top.protocol_assertions.failure_count;
		$display("tests passed %0d, failed %0d, assertion failures %0d", pass_count,
			fail_count, assertion_failures);
		if (fail_count == 0 && assertion_failures == 0 && pass_count == test_count) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
source/bus_slave_pkg.sv
source/input_synchronizer.sv
source/transaction_sequencer.sv
source/word_memory.sv
source/bus_slave_top.sv
testbench/bus_slave_assertions.sv
testbench/bus_slave_checker.sv
testbench/bus_slave_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := bus_slave_tb
FILE_LIST := build.f
BUILD_DIR := obj_dir
LOG       := simulation.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
